/* common/cop_cfg_pkg.sv */
// Co-processor configuration
// Register file geometry and random number generator constants
package cop_cfg_pkg;

    localparam int COP_NREGS   = 16; // Number of CPRs
    localparam int COP_XLEN    = 32; // Data path width
    localparam int COP_RADDR_W = 4;  // CPR address width

    // Galois feedback for x^32+x^22+x^2+x+1, shifting left
    localparam logic [31:0] LFSR_TAPS = 32'h0040_0007;

    // Reset state, any nonzero value
    localparam logic [31:0] LFSR_SEED = 32'hACE1_2468;

endpackage

/* common/cop_isa_pkg.sv */
// Co-processor instruction set definitions
// Opcodes, instruction classes, pack widths, result codes and the
// bit positions of every field in the 32-bit encoding
package cop_isa_pkg;

    // Funct field, bits 31:27
    typedef enum logic [4:0] {
        OP_MV2GPR = 5'd0,  // CPR to GPR move
        OP_MV2COP = 5'd1,  // GPR to CPR move
        OP_ADD    = 5'd2,  // Packed add
        OP_SUB    = 5'd3,  // Packed subtract
        OP_SLL    = 5'd4,  // Packed shift left
        OP_SRL    = 5'd5,  // Packed shift right
        OP_ROT    = 5'd6,  // Packed rotate right
        OP_XOR    = 5'd7,
        OP_AND    = 5'd8,
        OP_OR     = 5'd9,
        OP_RSEED  = 5'd10, // Seed the LFSR
        OP_RSAMP  = 5'd11  // Sample the LFSR
    } cop_op_t;

    typedef enum logic [1:0] {
        CLASS_MOVE    = 2'd0,
        CLASS_ARITH   = 2'd1,
        CLASS_BITWISE = 2'd2,
        CLASS_RANDOM  = 2'd3
    } cop_class_t;

    // Pack width, bits 26:25
    typedef enum logic [1:0] {
        PW_32 = 2'd0,
        PW_16 = 2'd1,
        PW_8  = 2'd2
    } cop_pw_t;

    typedef enum logic [2:0] {
        RES_SUCCESS = 3'd0,
        RES_BAD_INS = 3'd1
    } cop_result_t;

    localparam logic [6:0] COP_OPCODE    = 7'h2B; // custom-1 major opcode
    localparam logic [1:0] COP_PW_RSVD   = 2'b11; // Reserved pack width
    localparam int         COP_ZERO_BIT  = 7;     // Must be clear
    localparam int         COP_CRD_LSB   = 8;
    localparam int         COP_CRS1_LSB  = 12;
    localparam int         COP_CRS2_LSB  = 16;
    localparam int         COP_IMM_LSB   = 20;    // Also GPR rd
    localparam int         COP_PW_LSB    = 25;
    localparam int         COP_FUNCT_LSB = 27;

endpackage

/* dv/cop_tb.sv */
// Testbench for the crypto co-processor
// Replays the instruction trace over the CPU handshake, applies random
// response back-pressure and checks every response field
`timescale 1ns/1ps

module cop_tb;

    logic              g_clk;
    logic              g_resetn;
    logic              cpu_insn_req;
    logic [31:0]       cpu_insn_enc;
    logic [31:0]       cpu_rs1;
    logic              cpu_insn_ack;
    logic              cop_insn_ack;
    logic              cop_insn_rsp;
    logic              cop_wen;
    logic [4:0]        cop_waddr;
    logic [31:0]       cop_wdata;
    logic [2:0]        cop_result;
    logic [5:0][31:0]  trace_q[$];   // enc, rs1, wen, waddr, wdata, result
    int                errors;
    int                checks;
    int                cycles;
    int                cycle_limit;
    integer            seed;

    cop_top u_cop_top (.g_clk(g_clk), .g_resetn(g_resetn), .cpu_insn_req(cpu_insn_req),
        .cpu_insn_enc(cpu_insn_enc), .cpu_rs1(cpu_rs1), .cpu_insn_ack(cpu_insn_ack),
        .cop_insn_ack(cop_insn_ack), .cop_insn_rsp(cop_insn_rsp), .cop_wen(cop_wen),
        .cop_waddr(cop_waddr), .cop_wdata(cop_wdata), .cop_result(cop_result));

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    // Legal RNG ops finish a cycle later, everything else in the accept cycle
    function automatic int rsp_latency(input logic [31:0] enc);
        if (enc[7:0] == 8'h2B && (enc[31:27] == 5'd10 || enc[31:27] == 5'd11)) begin
            return 2;
        end
        return 1;
    endfunction

    task automatic load_trace;
        int               fd;
        string            line;
        logic [5:0][31:0] row;
        fd = $fopen("dv/cop_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file dv/cop_trace.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 2 && line.substr(0, 1) != "//" &&
                $sscanf(line, "%h %h %h %h %h %h", row[0], row[1], row[2], row[3],
                        row[4], row[5]) == 6) begin
                trace_q.push_back(row);
            end
        end
        $fclose(fd);
    endtask

    task automatic compare_response(input logic [5:0][31:0] row);
        check_val("cop_insn_rsp", 32'(cop_insn_rsp), 32'd1);
        check_val("cop_insn_ack", 32'(cop_insn_ack), 32'd0);
        check_val("cop_wen", 32'(cop_wen), row[2]);
        check_val("cop_waddr", 32'(cop_waddr), row[3]);
        check_val("cop_wdata", cop_wdata, row[4]);
        check_val("cop_result", 32'(cop_result), row[5]);
    endtask

    task automatic run_insn(input logic [5:0][31:0] row);
        int lat;
        int hold;
        @(posedge g_clk);
        cpu_insn_req <= 1'b1;
        cpu_insn_enc <= row[0];
        cpu_rs1      <= row[1];
        @(negedge g_clk);
        while (!cop_insn_ack) @(negedge g_clk);
        @(posedge g_clk);            // Accept edge
        cpu_insn_req <= 1'b0;
        cpu_insn_enc <= '0;          // CPU drops the encoding after accept
        cpu_rs1      <= '0;
        lat = 0;
        do begin
            @(negedge g_clk);
            lat++;
        end while (!cop_insn_rsp);
        check_val("rsp_latency", 32'(lat), 32'(rsp_latency(row[0])));
        hold = {$random(seed)} % 4;  // Extra back-pressure cycles
        compare_response(row);
        repeat (hold) begin
            @(posedge g_clk);
            @(negedge g_clk);
            compare_response(row);   // Must hold steady
        end
        @(posedge g_clk);
        cpu_insn_ack <= 1'b1;
        @(negedge g_clk);
        compare_response(row);
        @(posedge g_clk);            // Retire edge
        cpu_insn_ack <= 1'b0;
        @(negedge g_clk);
        check_val("cop_insn_ack", 32'(cop_insn_ack), 32'd1);  // Ready again
        check_val("cop_insn_rsp", 32'(cop_insn_rsp), 32'd0);
    endtask

    initial begin
        g_clk = 1'b0;
        forever #4 g_clk = ~g_clk;   // 8 ns period
    end

    // Cycle budget grows with the trace length
    initial begin
        cycles = 0;
        @(posedge g_clk);
        while (cycles < cycle_limit) begin
            @(posedge g_clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with the DUT still busy", cycles);
        $display("Checks run: %0d, errors: %0d", checks, errors + 1);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        errors       = 0;
        checks       = 0;
        seed         = 94;
        g_resetn     <= 1'b0;
        cpu_insn_req <= 1'b0;
        cpu_insn_enc <= '0;
        cpu_rs1      <= '0;
        cpu_insn_ack <= 1'b0;
        load_trace();
        cycle_limit = 20 * trace_q.size() + 50;
        if (trace_q.size() == 0) begin
            errors++;
            $display("No instructions were read from the trace");
        end
        repeat (2) @(posedge g_clk);
        g_resetn <= 1'b1;
        @(negedge g_clk);
        check_val("cop_insn_ack", 32'(cop_insn_ack), 32'd0);  // IDLE after reset
        check_val("cop_insn_rsp", 32'(cop_insn_rsp), 32'd0);
        @(negedge g_clk);
        check_val("cop_insn_ack", 32'(cop_insn_ack), 32'd1);  // Now WAITING
        foreach (trace_q[i]) begin
            run_insn(trace_q[i]);
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* dv/cop_trace.txt */
// Columns: encoding, cpu rs1, wen, waddr, wdata, result (all hex)
// One instruction per line, expected response on the same line
0800012B 12345678 0 00 12345678 0
0050102B 00000000 1 05 12345678 0
0800022B 0F0F80FF 0 00 0F0F80FF 0
0800032B 01FF8001 0 00 01FF8001 0
1003242B 00000000 0 00 110F0100 0
1203252B 00000000 0 00 110E0100 0
1403262B 00000000 0 00 100E0000 0
0060602B 00000000 1 06 100E0000 0
1802372B 00000000 0 00 F2EFFF02 0
1A02382B 00000000 0 00 F2F0FF02 0
1C02392B 00000000 0 00 F2F00002 0
0090902B 00000000 1 09 F2F00002 0
20401A2B 00000000 0 04 23456780 0
23401B2B 00000000 0 14 23406780 0
2C301C2B 00000000 0 03 02060A0F 0
32401D2B 00000000 0 04 41238567 0
30801E2B 00000000 0 08 78123456 0
00D0D02B 00000000 1 0D 41238567 0
3802142B 00000000 0 00 1D3BD687 0
4002152B 00000000 0 00 02040078 0
4802162B 00000000 0 00 1F3FD6FF 0
0040402B 00000000 1 04 1D3BD687 0
5000002B 80000001 0 00 00000000 0
58000F2B 00000000 0 00 00000000 0
00F0F02B 00000000 1 0F 00400005 0
F820002B 00000000 0 02 00000000 1
0070100B 00000000 0 07 00000000 1
1613242B 00000000 0 01 00000000 1
005010AB 00000000 0 05 00000000 1
0040402B 00000000 1 04 1D3BD687 0

/* hdl/cop_cprs.sv */
// Co-processor register file
// 16 x 32 flop array with two asynchronous read ports and one
// byte-enabled write port. Cleared at reset.
`timescale 1ns/1ps

module cop_cprs
    import cop_cfg_pkg::*;
(
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  logic [COP_RADDR_W-1:0] rs1_addr,
    output logic [COP_XLEN-1:0]    rs1_rdata,
    input  logic [COP_RADDR_W-1:0] rs2_addr,
    output logic [COP_XLEN-1:0]    rs2_rdata,
    input  logic [COP_XLEN/8-1:0]  rd_ben,
    input  logic [COP_RADDR_W-1:0] rd_addr,
    input  logic [COP_XLEN-1:0]    rd_wdata
);

    logic [COP_XLEN-1:0] regs [COP_NREGS];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < COP_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int b = 0; b < COP_XLEN/8; b++) begin
                if (rd_ben[b]) begin
                    regs[rd_addr][8*b +: 8] <= rd_wdata[8*b +: 8]; // Byte lane write
                end
            end
        end
    end

    assign rs1_rdata = regs[rs1_addr]; // Async read
    assign rs2_rdata = regs[rs2_addr];

endmodule

/* hdl/cop_idecode.sv */
// Co-processor instruction decoder
// Splits the 32-bit encoding into operation, class, pack width and
// register fields. Flags unknown functs, a foreign major opcode and
// the reserved pack width on lane arithmetic as illegal.
`timescale 1ns/1ps

module cop_idecode
    import cop_isa_pkg::*;
    import cop_cfg_pkg::*;
(
    input  logic [31:0]            insn_enc,
    output cop_op_t                op,
    output cop_class_t             iclass,
    output cop_pw_t                pw,
    output logic [COP_RADDR_W-1:0] crd,
    output logic [COP_RADDR_W-1:0] crs1,
    output logic [COP_RADDR_W-1:0] crs2,
    output logic [4:0]             imm5,
    output logic                   illegal
);

    logic known;    // Funct maps to an operation
    logic bad_pw;   // Reserved pack width present
    logic bad_major; // Not our opcode space

    assign op   = cop_op_t'(insn_enc[COP_FUNCT_LSB +: 5]);
    assign pw   = cop_pw_t'(insn_enc[COP_PW_LSB +: 2]);
    assign crd  = insn_enc[COP_CRD_LSB +: COP_RADDR_W];
    assign crs1 = insn_enc[COP_CRS1_LSB +: COP_RADDR_W];
    assign crs2 = insn_enc[COP_CRS2_LSB +: COP_RADDR_W];
    assign imm5 = insn_enc[COP_IMM_LSB +: 5];

    always_comb begin
        known  = 1'b1;
        iclass = CLASS_MOVE;
        case (op)
            OP_MV2GPR, OP_MV2COP:                  iclass = CLASS_MOVE;
            OP_ADD, OP_SUB, OP_SLL, OP_SRL, OP_ROT: iclass = CLASS_ARITH;
            OP_XOR, OP_AND, OP_OR:                 iclass = CLASS_BITWISE;
            OP_RSEED, OP_RSAMP:                    iclass = CLASS_RANDOM;
            default:                               known  = 1'b0;
        endcase
    end

    assign bad_major = (insn_enc[6:0] != COP_OPCODE) || insn_enc[COP_ZERO_BIT];
    assign bad_pw    = (iclass == CLASS_ARITH) && (insn_enc[COP_PW_LSB +: 2] == COP_PW_RSVD);
    assign illegal   = bad_major || !known || bad_pw;

endmodule

/* hdl/cop_rng.sv */
// Random number unit
// 32-bit Galois LFSR. Seed loads the CPU value, sample steps the
// register once and writes the new state to the CPR file.
// Done follows the issue by one cycle.
`timescale 1ns/1ps

module cop_rng
    import cop_isa_pkg::*;
    import cop_cfg_pkg::*;
(
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  rng_ivalid,
    input  cop_op_t               op,
    input  logic [COP_XLEN-1:0]   gpr_rs1,
    output logic                  rng_idone,
    output logic [COP_XLEN/8-1:0] rng_ben,
    output logic [COP_XLEN-1:0]   rng_wdata
);

    logic [31:0] lfsr;
    logic [31:0] lfsr_nxt;
    logic        samp_q; // Sample result pending

    assign lfsr_nxt = {lfsr[30:0], 1'b0} ^ (lfsr[31] ? LFSR_TAPS : 32'h0);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            lfsr      <= LFSR_SEED;
            rng_idone <= 1'b0;
            samp_q    <= 1'b0;
        end else begin
            rng_idone <= rng_ivalid;
            samp_q    <= rng_ivalid && (op == OP_RSAMP);
            if (rng_ivalid && op == OP_RSEED) begin
                lfsr <= (gpr_rs1 == '0) ? LFSR_SEED : gpr_rs1; // Zero would lock up
            end else if (rng_ivalid && op == OP_RSAMP) begin
                lfsr <= lfsr_nxt;
            end
        end
    end

    assign rng_ben   = {(COP_XLEN/8){samp_q}};
    assign rng_wdata = samp_q ? lfsr : '0;

    a_nonzero: assert property (@(posedge g_clk) disable iff (!g_resetn) lfsr != '0)
        else $error("rng: LFSR reached the all-zero state");

endmodule

/* hdl/cop_top.sv */
// Crypto co-processor top level
// Runs the request/acknowledge/response handshake with the CPU,
// dispatches decoded instructions to the packed ALU or the RNG,
// merges their CPR writebacks and registers the GPR response.
`timescale 1ns/1ps

module cop_top
    import cop_isa_pkg::*;
    import cop_cfg_pkg::*;
(
    input  logic                g_clk,
    input  logic                g_resetn,
    input  logic                cpu_insn_req,  // Instruction request
    input  logic [31:0]         cpu_insn_enc,
    input  logic [COP_XLEN-1:0] cpu_rs1,
    input  logic                cpu_insn_ack,  // Response accepted
    output logic                cop_insn_ack,  // Request accepted
    output logic                cop_insn_rsp,  // Instruction finished
    output logic                cop_wen,       // GPR write enable
    output logic [4:0]          cop_waddr,
    output logic [COP_XLEN-1:0] cop_wdata,
    output cop_result_t         cop_result
);

    typedef enum logic [1:0] {IDLE, WAITING, EXECUTING, FINISHED} cop_state_t;

    cop_state_t             state, state_nxt;
    logic                   ack_nxt, rsp_nxt;
    logic [31:0]            insn_q;    // Held encoding past the accept
    logic [31:0]            dec_enc;
    cop_op_t                op;
    cop_class_t             iclass;
    cop_pw_t                pw;
    logic [COP_RADDR_W-1:0] crd, crs1, crs2;
    logic [4:0]             imm5;
    logic                   illegal;
    logic [COP_XLEN-1:0]    crs1_rdata, crs2_rdata;
    logic                   palu_ivalid, palu_idone, rng_ivalid, rng_idone;
    logic [COP_XLEN/8-1:0]  palu_ben, rng_ben;
    logic [COP_XLEN-1:0]    palu_wdata, rng_wdata;
    logic                   insn_accept, insn_retire, insn_finish;

    assign insn_accept = cpu_insn_req && cop_insn_ack;
    assign insn_retire = cop_insn_rsp && cpu_insn_ack;
    assign insn_finish = palu_idone || rng_idone || (insn_accept && illegal);

    always_ff @(posedge g_clk) begin
        if (insn_accept) insn_q <= cpu_insn_enc;
    end
    assign dec_enc = (state == WAITING) ? cpu_insn_enc : insn_q; // CPU may drop enc

    assign palu_ivalid = insn_accept && !illegal && (iclass != CLASS_RANDOM);
    assign rng_ivalid  = insn_accept && !illegal && (iclass == CLASS_RANDOM);

    always_comb begin
        state_nxt = state;
        ack_nxt   = 1'b0;
        rsp_nxt   = 1'b0;
        case (state)
            IDLE: begin
                state_nxt = WAITING;
                ack_nxt   = 1'b1;
            end
            WAITING: begin
                ack_nxt = !insn_accept;
                if (insn_accept) begin
                    state_nxt = insn_finish ? FINISHED : EXECUTING; // Palu or bad insn done now
                    rsp_nxt   = insn_finish;
                end
            end
            EXECUTING: begin
                if (insn_finish) begin
                    state_nxt = FINISHED;
                    rsp_nxt   = 1'b1;
                end
            end
            default: begin
                if (insn_retire) begin
                    state_nxt = WAITING;
                    ack_nxt   = 1'b1;
                end else begin
                    rsp_nxt = 1'b1; // Back-pressure, hold response
                end
            end
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state        <= IDLE;
            cop_insn_ack <= 1'b0;
            cop_insn_rsp <= 1'b0;
            cop_wen      <= 1'b0;
            cop_result   <= RES_SUCCESS;
        end else begin
            state        <= state_nxt;
            cop_insn_ack <= ack_nxt;
            cop_insn_rsp <= rsp_nxt;
            if (insn_finish) begin
                cop_wen    <= !illegal && (op == OP_MV2GPR);
                cop_result <= illegal ? RES_BAD_INS : RES_SUCCESS;
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (insn_finish) begin
            cop_waddr <= imm5;       // GPR rd
            cop_wdata <= palu_wdata; // Only MV2GPR is meaningful
        end
    end

    cop_idecode u_idecode (.insn_enc(dec_enc), .op(op), .iclass(iclass), .pw(pw), .crd(crd),
        .crs1(crs1), .crs2(crs2), .imm5(imm5), .illegal(illegal));

    cop_cprs u_cprs (.g_clk(g_clk), .g_resetn(g_resetn), .rs1_addr(crs1),
        .rs1_rdata(crs1_rdata), .rs2_addr(crs2), .rs2_rdata(crs2_rdata),
        .rd_ben(palu_ben | rng_ben), .rd_addr(crd), .rd_wdata(palu_wdata | rng_wdata));

    cop_palu u_palu (.palu_ivalid(palu_ivalid), .palu_idone(palu_idone), .op(op), .pw(pw),
        .imm5(imm5), .gpr_rs1(cpu_rs1), .crs1_rdata(crs1_rdata), .crs2_rdata(crs2_rdata),
        .palu_ben(palu_ben), .palu_wdata(palu_wdata));

    cop_rng u_rng (.g_clk(g_clk), .g_resetn(g_resetn), .rng_ivalid(rng_ivalid), .op(op),
        .gpr_rs1(cpu_rs1), .rng_idone(rng_idone), .rng_ben(rng_ben), .rng_wdata(rng_wdata));

    a_ack_rsp_excl: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(cop_insn_ack && cop_insn_rsp)) else $error("top: ack and rsp both high");

    a_rsp_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (cop_insn_rsp && !cpu_insn_ack) |=>
            cop_insn_rsp && $stable({cop_wen, cop_waddr, cop_wdata, cop_result}))
        else $error("top: response changed under back-pressure");

endmodule

/* list.f */
common/cop_isa_pkg.sv
common/cop_cfg_pkg.sv
hdl/cop_idecode.sv
hdl/cop_cprs.sv
palu/cop_palu.sv
hdl/cop_rng.sv
hdl/cop_top.sv
dv/cop_tb.sv

/* palu/cop_palu.sv */
// Packed arithmetic unit
// Lane-wise add, subtract, shifts and rotate at 32, 16 or 8 bits,
// bitwise logic and the GPR/CPR moves. Purely combinational, so
// the done pulse follows the issue strobe.
`timescale 1ns/1ps

module cop_palu
    import cop_isa_pkg::*;
    import cop_cfg_pkg::*;
(
    input  logic                  palu_ivalid,
    output logic                  palu_idone,
    input  cop_op_t               op,
    input  cop_pw_t               pw,
    input  logic [4:0]            imm5,
    input  logic [COP_XLEN-1:0]   gpr_rs1,
    input  logic [COP_XLEN-1:0]   crs1_rdata,
    input  logic [COP_XLEN-1:0]   crs2_rdata,
    output logic [COP_XLEN/8-1:0] palu_ben,
    output logic [COP_XLEN-1:0]   palu_wdata
);

    logic [COP_XLEN-1:0]   sum;   // Lane add/sub result
    logic [COP_XLEN-1:0]   res;
    logic [COP_XLEN/8-1:0] ben;
    logic [7:0]            b_op;  // Second operand byte, inverted on SUB
    logic                  c;     // Byte carry
    logic                  cin;
    int                    lw;    // Lane width in bits
    int                    sh;    // Shift amount mod lane width

    // Bitwise per-lane shift of x, rotate is to the right
    function automatic logic [COP_XLEN-1:0] lane_shift(input logic [COP_XLEN-1:0] x,
                                                       input cop_op_t sop,
                                                       input int w,
                                                       input int s);
        logic [COP_XLEN-1:0] r;
        int                  base;
        int                  pos;
        r = '0;
        for (int i = 0; i < COP_XLEN; i++) begin
            base = i - (i % w);
            pos  = i % w;
            case (sop)
                OP_SLL:  r[i] = (pos >= s) ? x[base + pos - s] : 1'b0;
                OP_SRL:  r[i] = (pos + s < w) ? x[base + pos + s] : 1'b0;
                default: r[i] = x[base + (pos + s) % w];
            endcase
        end
        return r;
    endfunction

    assign lw = (pw == PW_32) ? 32 : (pw == PW_16) ? 16 : 8;
    assign sh = int'(imm5) % lw;

    // Ripple per byte, carry cut at each lane start
    always_comb begin
        sum = '0;
        c   = 1'b0;
        for (int b = 0; b < COP_XLEN/8; b++) begin
            cin  = (b == 0 || pw == PW_8 || (pw == PW_16 && b == 2)) ? (op == OP_SUB) : c;
            b_op = (op == OP_SUB) ? ~crs2_rdata[8*b +: 8] : crs2_rdata[8*b +: 8];
            {c, sum[8*b +: 8]} = crs1_rdata[8*b +: 8] + b_op + cin;
        end
    end

    always_comb begin
        res = '0;
        ben = '1;
        case (op)
            OP_MV2GPR: begin
                res = crs1_rdata; // Goes to the GPR, no CPR write
                ben = '0;
            end
            OP_MV2COP:               res = gpr_rs1;
            OP_ADD, OP_SUB:          res = sum;
            OP_SLL, OP_SRL, OP_ROT:  res = lane_shift(crs1_rdata, op, lw, sh);
            OP_XOR:                  res = crs1_rdata ^ crs2_rdata;
            OP_AND:                  res = crs1_rdata & crs2_rdata;
            OP_OR:                   res = crs1_rdata | crs2_rdata;
            default:                 ben = '0;
        endcase
    end

    assign palu_idone = palu_ivalid;
    assign palu_ben   = palu_ivalid ? ben : '0; // Quiet when idle
    assign palu_wdata = palu_ivalid ? res : '0;

    // Decoder and dispatch keep the reserved width out of lane ops
    always_comb begin
        if (palu_ivalid && op inside {OP_ADD, OP_SUB, OP_SLL, OP_SRL, OP_ROT}) begin
            assert (pw != COP_PW_RSVD) else $error("palu: reserved pack width issued");
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the co-processor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module cop_tb -f list.f -o cop_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/cop_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation binary exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1
